//--- Makefile
# Verilator build for the D-PHY lane and its testbench

VERILATOR ?= verilator
TOP       ?= tbDphyLane
RTL_TOP   ?= dphyLane
FILELIST  ?= dphyLane.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dphyLane.f
+incdir+.
dphyPkg.sv
escSerializer.sv
hsSerializer.sv
laneControl.sv
dphyLane.sv
tbClockGen.sv
tbDphyLane.sv

//--- dphyLane.sv
/*
 * D-PHY master data lane transmitter
 * lane controller with its HS word serializer and escape bit sequencer
 */
module dphyLane
    import dphyPkg::*;
(
    input  logic       ppi,
    input  logic       hs_clk,
    input  logic       enable,
    input  logic       txRequestHs,
    input  hsWord_t    txDataHs,
    input  logic       txRequestEsc,
    input  logic       txUlpsEsc,
    input  logic       txUlpsExit,
    output logic       stopState,
    output logic       txReadyHs,
    output logic       ulpsActiveNot,
    output lineState_t line
);

    // controller to HS serializer
    logic    hsLoad;
    hsWord_t hsWord;
    logic    hsBit;
    logic    hsLast;

    // controller to escape sequencer
    logic escStart;
    logic escMark;
    logic escBit;
    logic escDone;

    laneControl u_laneControl
    (
        .ppi           (ppi),
        .hs_clk        (hs_clk),
        .enable        (enable),
        .txRequestHs   (txRequestHs),
        .txDataHs      (txDataHs),
        .txRequestEsc  (txRequestEsc),
        .txUlpsEsc     (txUlpsEsc),
        .txUlpsExit    (txUlpsExit),
        .hsBit         (hsBit),
        .hsLast        (hsLast),
        .escMark       (escMark),
        .escBit        (escBit),
        .escDone       (escDone),
        .hsLoad        (hsLoad),
        .hsWord        (hsWord),
        .escStart      (escStart),
        .stopState     (stopState),
        .txReadyHs     (txReadyHs),
        .ulpsActiveNot (ulpsActiveNot),
        .line          (line)
    );

    hsSerializer u_hsSerializer
    (
        .ppi    (ppi),
        .hs_clk (hs_clk),
        .hsLoad (hsLoad),
        .hsWord (hsWord),
        .hsBit  (hsBit),
        .hsLast (hsLast)
    );

    escSerializer u_escSerializer
    (
        .ppi      (ppi),
        .hs_clk   (hs_clk),
        .escStart (escStart),
        .escMark  (escMark),
        .escBit   (escBit),
        .escDone  (escDone)
    );

endmodule

//--- dphyLane_config.svh
/*
 * D-PHY data lane timing
 * fixed cycle counts for every lane interval plus the sync byte and ULPS entry code
 */
`ifndef DPHYLANE_CONFIG_SVH
`define DPHYLANE_CONFIG_SVH

// initialization interval after enable, line held at LP-11
`define INIT_CYCLES 16'd20

// LP request phase before HS or escape entry
`define LPX_CYCLES 16'd4

// HS start-up, LP-00 then HS-0 before the sync byte
`define HS_PREPARE_CYCLES 16'd5
`define HS_ZERO_CYCLES 16'd10

// HS end of burst, inverted last bit then LP-11
`define HS_TRAIL_CYCLES 16'd6
`define HS_EXIT_CYCLES 16'd8

// one half of an escape bit, mark or spacer
`define ESC_HALF_CYCLES 16'd2

// mark-1 hold when leaving ULPS
`define WAKEUP_CYCLES 16'd30

// leader byte of every HS burst
`define HS_SYNC_BYTE 8'hB8

// escape command code for ULPS entry, sent LSB first
`define ULPS_ENTRY_CODE 8'h1E

`endif

//--- dphyPkg.sv
/*
 * D-PHY lane types
 * line states, controller states and the HS payload word
 */
package dphyPkg;

    // state of the lane wire pair as seen by the receiver
    // nine values, so the encoding needs four bits
    typedef enum logic [3:0]
    {
        LineOff,
        Lp11,
        Lp01,
        Lp10,
        Lp00,
        Hs0,
        Hs1,
        Mark0,
        Mark1
    } lineState_t;

    // lane controller FSM states
    typedef enum logic [3:0]
    {
        Off,
        Init,
        Stop,
        HsPrepare,
        HsZero,
        HsSync,
        HsData,
        HsTrail,
        HsExit,
        EscEntry,
        EscCmd,
        Ulps,
        UlpsWake,
        UlpsHold
    } laneState_t;

    // one HS payload word
    typedef logic [7:0] hsWord_t;

endpackage

//--- escSerializer.sv
/*
 * escape-mode bit sequencer
 * sends the ULPS entry command as spaced mark bits, each bit a mark half then a spacer half
 */
`include "dphyLane_config.svh"

module escSerializer
(
    input  logic ppi,
    input  logic hs_clk,
    input  logic escStart,
    output logic escMark,
    output logic escBit,
    output logic escDone
);

    // entry bits 1 then 0, then the command code LSB first
    localparam logic [9:0] EntrySeq = {`ULPS_ENTRY_CODE, 2'b01};

    logic        active;
    logic        markHalf;
    logic [3:0]  bitIdx;
    logic [15:0] halfCnt;
    logic        halfEnd;
    logic        seqEnd;

    assign halfEnd = (halfCnt == 16'd0);
    assign seqEnd  = active && !markHalf && halfEnd && (bitIdx == 4'd9);

    assign escMark = active && markHalf;
    assign escBit  = EntrySeq[bitIdx];

    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            active   <= 1'b0;
            markHalf <= 1'b0;
            bitIdx   <= 4'd0;
            halfCnt  <= 16'd0;
            escDone  <= 1'b0;
        end
        else
        begin
            escDone <= seqEnd;
            if (escStart)
            begin
                active   <= 1'b1;
                markHalf <= 1'b1;
                bitIdx   <= 4'd0;
                halfCnt  <= `ESC_HALF_CYCLES - 16'd1;
            end
            else if (active)
            begin
                if (!halfEnd)
                    halfCnt <= halfCnt - 16'd1;
                else if (markHalf)
                begin
                    // mark done, spacer follows
                    markHalf <= 1'b0;
                    halfCnt  <= `ESC_HALF_CYCLES - 16'd1;
                end
                else if (seqEnd)
                    active <= 1'b0;
                else
                begin
                    bitIdx   <= bitIdx + 4'd1;
                    markHalf <= 1'b1;
                    halfCnt  <= `ESC_HALF_CYCLES - 16'd1;
                end
            end
        end
    end

endmodule

//--- hsSerializer.sv
/*
 * HS word serializer
 * shifts one byte out LSB first and flags its last bit for back-to-back loading
 */
module hsSerializer
    import dphyPkg::*;
(
    input  logic    ppi,
    input  logic    hs_clk,
    input  logic    hsLoad,
    input  hsWord_t hsWord,
    output logic    hsBit,
    output logic    hsLast
);

    hsWord_t    shiftReg;
    logic [2:0] bitCnt;
    logic       busy;

    assign hsBit  = shiftReg[0];
    assign hsLast = busy && (bitCnt == 3'd7);

    // data path, first bit shows the cycle after the load edge
    always_ff @(posedge ppi)
    begin
        if (hsLoad)
            shiftReg <= hsWord;
        else
            shiftReg <= {1'b0, shiftReg[7:1]};
    end

    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            bitCnt <= 3'd0;
            busy   <= 1'b0;
        end
        else if (hsLoad)
        begin
            bitCnt <= 3'd0;
            busy   <= 1'b1;
        end
        else if (busy)
        begin
            bitCnt <= bitCnt + 3'd1;
            // word finished with nothing queued behind it
            if (hsLast)
                busy <= 1'b0;
        end
    end

endmodule

//--- laneControl.sv
/*
 * D-PHY lane controller
 * lane FSM, interval timer, PPI status and the registered line-state encoder
 */
`include "dphyLane_config.svh"

module laneControl
    import dphyPkg::*;
(
    input  logic       ppi,
    input  logic       hs_clk,
    input  logic       enable,
    input  logic       txRequestHs,
    input  hsWord_t    txDataHs,
    input  logic       txRequestEsc,
    input  logic       txUlpsEsc,
    input  logic       txUlpsExit,
    input  logic       hsBit,
    input  logic       hsLast,
    input  logic       escMark,
    input  logic       escBit,
    input  logic       escDone,
    output logic       hsLoad,
    output hsWord_t    hsWord,
    output logic       escStart,
    output logic       stopState,
    output logic       txReadyHs,
    output logic       ulpsActiveNot,
    output lineState_t line
);

    laneState_t state;
    laneState_t nextState;
    logic [15:0] phaseTimer;
    logic [15:0] nextTimer;
    logic        timerDone;
    logic        lastHsBit;
    lineState_t  lineNext;

    assign timerDone = (phaseTimer == 16'd0);

    // word strobe in the serializer's last bit cycle, the line shows that bit one cycle later
    assign txReadyHs = hsLast && ((state == HsSync) || (state == HsData));

    // sync byte leads the burst, host words follow back to back
    assign hsLoad = ((state == HsZero) && timerDone) || (txReadyHs && txRequestHs);
    assign hsWord = (state == HsZero) ? `HS_SYNC_BYTE : txDataHs;

    assign escStart = (state == EscEntry) && timerDone;

    always_comb
    begin
        nextState = state;
        nextTimer = timerDone ? 16'd0 : phaseTimer - 16'd1;
        case (state)
            Off:
            begin
                nextState = Init;
                nextTimer = `INIT_CYCLES - 16'd1;
            end
            Init:
            begin
                if (timerDone)
                    nextState = Stop;
            end
            Stop:
            begin
                // HS wins over escape when both are requested
                if (txRequestHs)
                begin
                    nextState = HsPrepare;
                    nextTimer = `LPX_CYCLES + `HS_PREPARE_CYCLES - 16'd1;
                end
                else if (txRequestEsc && txUlpsEsc)
                begin
                    nextState = EscEntry;
                    nextTimer = `LPX_CYCLES - 16'd1;
                end
            end
            HsPrepare:
            begin
                if (timerDone)
                begin
                    nextState = HsZero;
                    nextTimer = `HS_ZERO_CYCLES - 16'd1;
                end
            end
            HsZero:
            begin
                if (timerDone)
                    nextState = HsSync;
            end
            HsSync, HsData:
            begin
                if (hsLast)
                begin
                    if (txRequestHs)
                        nextState = HsData;
                    else
                    begin
                        nextState = HsTrail;
                        nextTimer = `HS_TRAIL_CYCLES - 16'd1;
                    end
                end
            end
            HsTrail:
            begin
                if (timerDone)
                begin
                    nextState = HsExit;
                    nextTimer = `HS_EXIT_CYCLES - 16'd1;
                end
            end
            HsExit:
            begin
                if (timerDone)
                    nextState = Stop;
            end
            EscEntry:
            begin
                if (timerDone)
                    nextState = EscCmd;
            end
            EscCmd:
            begin
                if (escDone)
                    nextState = Ulps;
            end
            Ulps:
            begin
                if (txUlpsExit)
                begin
                    nextState = UlpsWake;
                    nextTimer = `WAKEUP_CYCLES - 16'd1;
                end
            end
            UlpsWake:
            begin
                if (timerDone)
                    nextState = txRequestEsc ? UlpsHold : Stop;
            end
            UlpsHold:
            begin
                if (!txRequestEsc)
                    nextState = Stop;
            end
            default:
            begin
                nextState = Off;
            end
        endcase
        // shutdown overrides everything
        if (!enable)
        begin
            nextState = Off;
            nextTimer = 16'd0;
        end
    end

    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            state      <= Off;
            phaseTimer <= 16'd0;
        end
        else
        begin
            state      <= nextState;
            phaseTimer <= nextTimer;
        end
    end

    // last bit of the burst, inverted for the trail
    always_ff @(posedge ppi)
    begin
        if (hsLast)
            lastHsBit <= hsBit;
    end

    always_comb
    begin
        case (state)
            Init, Stop, HsExit:
                lineNext = Lp11;
            // LPX of LP-01 first, then the prepare interval of LP-00
            HsPrepare:
                lineNext = (phaseTimer >= `HS_PREPARE_CYCLES) ? Lp01 : Lp00;
            HsZero:
                lineNext = Hs0;
            HsSync, HsData:
                lineNext = hsBit ? Hs1 : Hs0;
            HsTrail:
                lineNext = lastHsBit ? Hs0 : Hs1;
            EscEntry:
                lineNext = Lp10;
            EscCmd:
                lineNext = escMark ? (escBit ? Mark1 : Mark0) : Lp00;
            Ulps:
                lineNext = Lp00;
            UlpsWake, UlpsHold:
                lineNext = Mark1;
            default:
                lineNext = LineOff;
        endcase
    end

    // line and status follow the state by one cycle, except on shutdown
    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            line          <= LineOff;
            stopState     <= 1'b0;
            ulpsActiveNot <= 1'b1;
        end
        else if (!enable)
        begin
            line          <= LineOff;
            stopState     <= 1'b0;
            ulpsActiveNot <= 1'b1;
        end
        else
        begin
            line          <= lineNext;
            stopState     <= (state == Stop);
            ulpsActiveNot <= !((state == Ulps) || ((state == EscCmd) && escDone));
        end
    end

endmodule

//--- tbClockGen.sv
/*
 * testbench clock and reset
 * 100 ns ppi clock, hs_clk reset held low for the first four cycles
 */
module tbClockGen
(
    output logic ppi,
    output logic hs_clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        ppi = 1'b0;
        forever #50 ppi = ~ppi;
    end

    initial
    begin
        hs_clk = 1'b0;
        repeat (4) @(posedge ppi);
        hs_clk <= 1'b1;
    end

endmodule

//--- tbDphyLane.sv
/*
 * testbench for the D-PHY data lane transmitter
 * random HS bursts and ULPS rounds checked cycle by cycle against a line model
 */
`include "dphyLane_config.svh"

module tbDphyLane
    import dphyPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int Rounds = 20;
    localparam int MaxWords = 16;
    localparam int CycleLimit = Rounds * (MaxWords * 8 + 200) + 500;

    logic       ppi;
    logic       hs_clk;
    logic       enable;
    logic       txRequestHs;
    hsWord_t    txDataHs;
    logic       txRequestEsc;
    logic       txUlpsEsc;
    logic       txUlpsExit;
    logic       stopState;
    logic       txReadyHs;
    logic       ulpsActiveNot;
    lineState_t line;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    // expected line state, one entry per ppi cycle
    lineState_t expLine[$];

    tbClockGen u_clockGen
    (
        .ppi    (ppi),
        .hs_clk (hs_clk)
    );

    dphyLane u_dphyLane
    (
        .ppi           (ppi),
        .hs_clk        (hs_clk),
        .enable        (enable),
        .txRequestHs   (txRequestHs),
        .txDataHs      (txDataHs),
        .txRequestEsc  (txRequestEsc),
        .txUlpsEsc     (txUlpsEsc),
        .txUlpsExit    (txUlpsExit),
        .stopState     (stopState),
        .txReadyHs     (txReadyHs),
        .ulpsActiveNot (ulpsActiveNot),
        .line          (line)
    );

    always @(posedge ppi)
    begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit)
        begin
            $display("timeout: the run did not finish within %0d cycles", CycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("** Error at %0.1f ns: %s expected %0h, got %0h",
                     $realtime, name, expected, actual);
        end
    endtask

    function automatic void pushRun(input lineState_t s, input int n);
        for (int i = 0; i < n; i++)
            expLine.push_back(s);
    endfunction

    // one HS byte on the line sent LSB first
    function automatic void pushByte(input hsWord_t b);
        for (int i = 0; i < 8; i++)
            expLine.push_back(b[i] ? Hs1 : Hs0);
    endfunction

    // outputs are sampled on the falling edge away from input changes
    task automatic nextSample();
        @(posedge ppi);
        @(negedge ppi);
    endtask

    task automatic waitWhileLine(input lineState_t s);
        do
        begin
            nextSample();
        end
        while (line == s);
    endtask

    task automatic runInit();
        int cnt;
        cnt = 0;
        @(posedge ppi);
        enable <= 1'b1;
        waitWhileLine(LineOff);
        while (!stopState)
        begin
            checkValue("line", 32'(Lp11), 32'(line));
            cnt++;
            nextSample();
        end
        checkValue("init cycles", 32'(`INIT_CYCLES), 32'(cnt));
        checkValue("line", 32'(Lp11), 32'(line));
    endtask

    task automatic runBurst(input int n);
        hsWord_t    words[$];
        int         nextIdx;
        int         strobes;
        logic       drive;
        lineState_t exp;
        for (int i = 0; i < n; i++)
            words.push_back(8'($urandom()));
        expLine.delete();
        pushRun(Lp01, int'(`LPX_CYCLES));
        pushRun(Lp00, int'(`HS_PREPARE_CYCLES));
        pushRun(Hs0, int'(`HS_ZERO_CYCLES));
        pushByte(`HS_SYNC_BYTE);
        foreach (words[i])
            pushByte(words[i]);
        // trail repeats the inverse of the final bit
        pushRun(words[n - 1][7] ? Hs0 : Hs1, int'(`HS_TRAIL_CYCLES));
        pushRun(Lp11, int'(`HS_EXIT_CYCLES));
        nextIdx = 1;
        strobes = 0;
        @(posedge ppi);
        txDataHs    <= words[0];
        txRequestHs <= 1'b1;
        waitWhileLine(Lp11);
        while (expLine.size() > 0)
        begin
            exp = expLine.pop_front();
            checkValue("line", 32'(exp), 32'(line));
            checkValue("stopState", 32'd0, 32'(stopState));
            drive = txReadyHs;
            if (txReadyHs)
                strobes++;
            @(posedge ppi);
            // host moves to the next word on the edge closing the strobe
            if (drive)
            begin
                if (nextIdx < n)
                begin
                    txDataHs <= words[nextIdx];
                    nextIdx++;
                end
                else
                    txRequestHs <= 1'b0;
            end
            @(negedge ppi);
        end
        checkValue("line", 32'(Lp11), 32'(line));
        checkValue("stopState", 32'd1, 32'(stopState));
        checkValue("txReadyHs strobes", 32'(n + 1), 32'(strobes));
    endtask

    task automatic runUlps(input int dwell, input int hold);
        logic [9:0] seq;
        int         markCnt;
        lineState_t exp;
        // entry bits 1 and 0 followed by the command LSB first
        seq[0]   = 1'b1;
        seq[1]   = 1'b0;
        seq[9:2] = `ULPS_ENTRY_CODE;
        expLine.delete();
        pushRun(Lp10, int'(`LPX_CYCLES));
        for (int i = 0; i < 10; i++)
        begin
            pushRun(seq[i] ? Mark1 : Mark0, int'(`ESC_HALF_CYCLES));
            pushRun(Lp00, int'(`ESC_HALF_CYCLES));
        end
        @(posedge ppi);
        txRequestEsc <= 1'b1;
        txUlpsEsc    <= 1'b1;
        waitWhileLine(Lp11);
        while (expLine.size() > 0)
        begin
            exp = expLine.pop_front();
            checkValue("line", 32'(exp), 32'(line));
            checkValue("ulpsActiveNot", 32'd1, 32'(ulpsActiveNot));
            nextSample();
        end
        for (int i = 0; i < dwell; i++)
        begin
            checkValue("line", 32'(Lp00), 32'(line));
            checkValue("ulpsActiveNot", 32'd0, 32'(ulpsActiveNot));
            nextSample();
        end
        @(posedge ppi);
        txUlpsExit <= 1'b1;
        waitWhileLine(Lp00);
        markCnt = 0;
        while (line == Mark1)
        begin
            checkValue("ulpsActiveNot", 32'd1, 32'(ulpsActiveNot));
            markCnt++;
            @(posedge ppi);
            if (markCnt == 1)
                txUlpsExit <= 1'b0;
            // release the escape request so the lane leaves after the wakeup plus hold
            if (markCnt == int'(`WAKEUP_CYCLES) - 2 + hold)
            begin
                txRequestEsc <= 1'b0;
                txUlpsEsc    <= 1'b0;
            end
            @(negedge ppi);
        end
        checkValue("mark1 cycles", 32'(int'(`WAKEUP_CYCLES) + hold), 32'(markCnt));
        checkValue("line", 32'(Lp11), 32'(line));
        checkValue("stopState", 32'd1, 32'(stopState));
    endtask

    task automatic dropEnable();
        @(posedge ppi);
        enable       <= 1'b0;
        txRequestHs  <= 1'b0;
        txRequestEsc <= 1'b0;
        txUlpsEsc    <= 1'b0;
        txUlpsExit   <= 1'b0;
        nextSample();
        checkValue("line", 32'(LineOff), 32'(line));
        checkValue("stopState", 32'd0, 32'(stopState));
        checkValue("txReadyHs", 32'd0, 32'(txReadyHs));
    endtask

    initial
    begin
        enable       = 1'b0;
        txRequestHs  = 1'b0;
        txDataHs     = 8'h00;
        txRequestEsc = 1'b0;
        txUlpsEsc    = 1'b0;
        txUlpsExit   = 1'b0;
        void'($urandom(32'h76e8ea01));
        @(posedge hs_clk);
        @(negedge ppi);
        checkValue("line", 32'(LineOff), 32'(line));
        checkValue("stopState", 32'd0, 32'(stopState));
        checkValue("txReadyHs", 32'd0, 32'(txReadyHs));
        checkValue("ulpsActiveNot", 32'd1, 32'(ulpsActiveNot));
        runInit();
        for (int r = 0; r < Rounds; r++)
        begin
            if ($urandom_range(1, 0) == 1)
                runBurst(int'($urandom_range(MaxWords, 1)));
            else
                runUlps(int'($urandom_range(40, 5)), int'($urandom_range(8, 0)));
        end
        // shutdown in the middle of a burst and then during ULPS
        @(posedge ppi);
        txDataHs    <= 8'($urandom());
        txRequestHs <= 1'b1;
        waitWhileLine(Lp11);
        repeat ($urandom_range(60, 25)) nextSample();
        dropEnable();
        runInit();
        @(posedge ppi);
        txRequestEsc <= 1'b1;
        txUlpsEsc    <= 1'b1;
        waitWhileLine(Lp11);
        while (ulpsActiveNot)
            nextSample();
        dropEnable();
        checkValue("ulpsActiveNot", 32'd1, 32'(ulpsActiveNot));
        runInit();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
